/* matmul_pkg.sv */
// ----------------------------------------------------------------------
// Shared sizes, Q8.8 format, pipeline latency and controller states
// for the block matrix multiplier
// ----------------------------------------------------------------------

package matmul_pkg;

    // Fixed-point element, Q8.8 signed
    localparam int data_w = 16;
    localparam int frac_w = 8;             // Products shift right by this

    // Systolic array and memory word
    localparam int block_size = 2;         // 2x2 PE array
    localparam int chunk_size = block_size * block_size;  // Elements per word
    localparam int word_w = data_w * chunk_size;          // 64

    // Matrix shapes, C = A * W^T
    localparam int inner_dim = 4;
    localparam int in_outer_dim = 4;       // Rows of A
    localparam int wt_outer_dim = 4;       // Rows of W

    localparam int inner_chunks = inner_dim / block_size;
    localparam int tile_rows = in_outer_dim / block_size;
    localparam int tile_cols = wt_outer_dim / block_size;
    localparam int tile_count = tile_rows * tile_cols;

    // RAM depths in words, one 2x2 block per word
    localparam int in_depth = tile_rows * inner_chunks;
    localparam int wt_depth = tile_cols * inner_chunks;
    localparam int addr_w = $clog2((in_depth > wt_depth) ? in_depth : wt_depth);

    localparam int acc_w = 32;             // Partial sums wrap here

    // block_load to block_finish
    localparam int sys_latency = 5;

    // Main controller FSM
    typedef enum logic [2:0] {
        st_idle,       // Waiting for start
        st_read,       // RAM read issued
        st_compute,    // Block in flight through the array
        st_accum,      // Partial block lands in accumulator
        st_emit,       // Tile handed out, advance tile counters
        st_done        // Run finished, done held
    } ctrl_state_t;

endpackage

/* tile_ram.sv */
// ----------------------------------------------------------------------
// Simple dual-port block RAM, byte write enables, registered read
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tile_ram
    import matmul_pkg::*;
#(
    parameter int depth = 4
) (
    input  logic                  accumulator_done_top,
    input  logic                  wr_en,
    input  logic [word_w/8-1:0]   wr_be,
    input  logic [addr_w-1:0]     wr_addr,
    input  logic [word_w-1:0]     wr_data,
    input  logic                  rd_en,
    input  logic [addr_w-1:0]     rd_addr,
    output logic [word_w-1:0]     rd_data
);

    logic [word_w-1:0] mem [depth];

    // Host write port, one enable per byte lane
    always_ff @(posedge accumulator_done_top) begin
        if (wr_en) begin
            for (int b = 0; b < word_w / 8; b++) begin
                if (wr_be[b]) begin
                    mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
    end

    // Read port, data one cycle after rd_en and held until next read
    always_ff @(posedge accumulator_done_top) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* mac_pe.sv */
// ----------------------------------------------------------------------
// Output-stationary systolic PE
// Q8.8 multiply, wrapping accumulate, registered operand forwarding
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module mac_pe
    import matmul_pkg::*;
(
    input  logic              accumulator_done_top,
    input  logic              rst_n,
    input  logic              clear,      // Load instead of add
    input  logic [data_w-1:0] a_in,       // From the left
    input  logic [data_w-1:0] w_in,       // From above
    output logic [data_w-1:0] a_out,      // To the right
    output logic [data_w-1:0] w_out,      // Downward
    output logic [acc_w-1:0]  sum
);

    logic signed [2*data_w-1:0] product;
    logic signed [acc_w-1:0]    scaled;

    // Full Q16.16 product, back to Q8.8 scale
    assign product = $signed(a_in) * $signed(w_in);
    assign scaled  = acc_w'(product >>> frac_w);   // Arithmetic shift keeps sign

    // Operand pipeline, zeros after reset so idle PEs add nothing
    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            a_out <= '0;
            w_out <= '0;
        end else begin
            a_out <= a_in;
            w_out <= w_in;
        end
    end

    // Running dot product
    always_ff @(posedge accumulator_done_top) begin
        if (clear) begin
            sum <= scaled;                  // First term of a new block
        end else begin
            sum <= sum + scaled;            // Wraps at acc_w
        end
    end

endmodule

/* systolic_block.sv */
// ----------------------------------------------------------------------
// 2x2 systolic array computing one A x W^T partial block
// Operand capture, skewed feed, PE grid, finish timing
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module systolic_block
    import matmul_pkg::*;
(
    input  logic                        accumulator_done_top,
    input  logic                        rst_n,
    input  logic                        block_load,    // Words valid this cycle
    input  logic [word_w-1:0]           a_block,
    input  logic [word_w-1:0]           w_block,
    output logic                        block_finish,  // block_out valid
    output logic [chunk_size*acc_w-1:0] block_out
);

    logic [word_w-1:0]      a_q;
    logic [word_w-1:0]      w_q;
    logic [sys_latency-1:0] load_sr;                  // One bit per cycle in flight

    // Edge feeds into row r and column c
    logic [data_w-1:0] a_feed [block_size];
    logic [data_w-1:0] w_feed [block_size];

    // Operand links, extra slot on the far edge of each row and column
    logic [data_w-1:0] a_link [block_size][block_size+1];
    logic [data_w-1:0] w_link [block_size+1][block_size];

    // Hold both blocks while they are skewed in
    always_ff @(posedge accumulator_done_top) begin
        if (block_load) begin
            a_q <= a_block;
            w_q <= w_block;
        end
    end

    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            load_sr <= '0;
        end else begin
            load_sr <= {load_sr[sys_latency-2:0], block_load};
        end
    end

    // Row r of A enters at step r + k, row c of W at step c + k
    // Zeros outside the window keep the sums stable
    always_comb begin
        for (int r = 0; r < block_size; r++) begin
            a_feed[r] = '0;
            w_feed[r] = '0;
            for (int k = 0; k < block_size; k++) begin
                if (load_sr[r + k]) begin
                    a_feed[r] = a_q[data_w*(block_size*r + k) +: data_w];  // A(r,k)
                    w_feed[r] = w_q[data_w*(block_size*r + k) +: data_w];  // W(r,k)
                end
            end
        end
    end

    // PE grid, A moves right and W moves down
    for (genvar r = 0; r < block_size; r++) begin : g_row
        assign a_link[r][0] = a_feed[r];
        assign w_link[0][r] = w_feed[r];
        for (genvar c = 0; c < block_size; c++) begin : g_col
            mac_pe pe_i (
                .accumulator_done_top (accumulator_done_top),
                .rst_n                (rst_n),
                .clear                (load_sr[0]),            // First step of the block
                .a_in                 (a_link[r][c]),
                .w_in                 (w_link[r][c]),
                .a_out                (a_link[r][c+1]),
                .w_out                (w_link[r+1][c]),
                .sum                  (block_out[acc_w*(block_size*r + c) +: acc_w])
            );
        end
    end

    // Last PE settles sys_latency cycles after the load
    assign block_finish = load_sr[sys_latency-1];

endmodule

/* block_accumulator.sv */
// ----------------------------------------------------------------------
// Tile accumulator over the inner dimension
// Per-lane sums, chunk count, truncated tile and done pulse
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module block_accumulator
    import matmul_pkg::*;
(
    input  logic                        accumulator_done_top,
    input  logic                        rst_n,
    input  logic                        acc_clear,     // Start of a new tile
    input  logic                        block_finish,  // Partial block arriving
    input  logic [chunk_size*acc_w-1:0] block_out,
    output logic                        tile_done,     // One-cycle pulse
    output logic [word_w-1:0]           tile_sum       // Four Q8.8 results
);

    logic [acc_w-1:0]                  acc       [chunk_size];
    logic [acc_w-1:0]                  lane_next [chunk_size];
    logic [$clog2(inner_chunks)-1:0]   chunk_cnt;
    logic                              last_chunk;

    assign last_chunk = (chunk_cnt == inner_chunks - 1);

    always_comb begin
        for (int i = 0; i < chunk_size; i++) begin
            lane_next[i] = acc[i] + block_out[acc_w*i +: acc_w];   // Wrapping add
        end
    end

    // Lane sums and the finished tile
    always_ff @(posedge accumulator_done_top) begin
        for (int i = 0; i < chunk_size; i++) begin
            if (acc_clear) begin
                acc[i] <= '0;
            end else if (block_finish) begin
                acc[i] <= lane_next[i];
            end
            if (block_finish && last_chunk) begin
                tile_sum[data_w*i +: data_w] <= lane_next[i][data_w-1:0];  // Low 16 bits
            end
        end
    end

    // Chunk count and done pulse
    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            chunk_cnt <= '0;
            tile_done <= 1'b0;
        end else begin
            tile_done <= 1'b0;
            if (acc_clear) begin
                chunk_cnt <= '0;
            end else if (block_finish) begin
                if (last_chunk) begin
                    chunk_cnt <= '0;
                    tile_done <= 1'b1;      // Pulse one cycle after last finish
                end else begin
                    chunk_cnt <= chunk_cnt + 1'b1;
                end
            end
        end
    end

endmodule

/* matmul_controller.sv */
// ----------------------------------------------------------------------
// Main controller FSM
// Tile ordering, RAM read addressing, block load and accumulator clear,
// start gating and the done flag
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module matmul_controller
    import matmul_pkg::*;
(
    input  logic              accumulator_done_top,
    input  logic              rst_n,
    input  logic              start,
    input  logic              tile_done,
    output logic              in_rd_en,
    output logic              wt_rd_en,
    output logic [addr_w-1:0] in_rd_addr,
    output logic [addr_w-1:0] wt_rd_addr,
    output logic              block_load,
    output logic              acc_clear,
    output logic              done
);

    ctrl_state_t                     state;
    logic [$clog2(inner_chunks)-1:0] chunk_cnt;    // Inner chunk k
    logic [$clog2(tile_rows)-1:0]    row_cnt;      // Tile row i, A side
    logic [$clog2(tile_cols)-1:0]    col_cnt;      // Tile column j, W side
    logic [$clog2(tile_count)-1:0]   tile_cnt;
    logic [$clog2(sys_latency)-1:0]  wait_cnt;     // Cycles into st_compute
    logic                            start_ok;

    // Busy runs ignore start
    assign start_ok = start && ((state == st_idle) || (state == st_done));

    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            state     <= st_idle;
            chunk_cnt <= '0;
            row_cnt   <= '0;
            col_cnt   <= '0;
            tile_cnt  <= '0;
            wait_cnt  <= '0;
            done      <= 1'b0;
        end else begin
            case (state)
                st_idle, st_done: begin
                    if (start_ok) begin
                        state     <= st_read;
                        chunk_cnt <= '0;
                        row_cnt   <= '0;
                        col_cnt   <= '0;
                        tile_cnt  <= '0;
                    end
                end
                st_read: begin
                    state    <= st_compute;         // Data valid next cycle
                    wait_cnt <= '0;
                end
                st_compute: begin
                    if (wait_cnt == sys_latency - 1) begin
                        state <= st_accum;          // Lines up with block_finish
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                st_accum: begin
                    if (chunk_cnt == inner_chunks - 1) begin
                        chunk_cnt <= '0;
                        state     <= st_emit;
                    end else begin
                        chunk_cnt <= chunk_cnt + 1'b1;
                        state     <= st_read;
                    end
                end
                st_emit: begin
                    if (tile_done) begin
                        tile_cnt <= tile_cnt + 1'b1;
                        // Row-major, column fastest
                        if (col_cnt == tile_cols - 1) begin
                            col_cnt <= '0;
                            row_cnt <= row_cnt + 1'b1;
                        end else begin
                            col_cnt <= col_cnt + 1'b1;
                        end
                        state <= (tile_cnt == tile_count - 1) ? st_done : st_read;
                    end
                end
                default: state <= st_idle;
            endcase

            // Set a cycle after entering st_done, held until the next run
            if (start_ok) begin
                done <= 1'b0;
            end else if (state == st_done) begin
                done <= 1'b1;
            end
        end
    end

    // Both RAMs read together
    assign in_rd_en   = (state == st_read);
    assign wt_rd_en   = (state == st_read);
    assign in_rd_addr = addr_w'(chunk_cnt + inner_chunks * row_cnt);
    assign wt_rd_addr = addr_w'(chunk_cnt + inner_chunks * col_cnt);

    assign block_load = (state == st_compute) && (wait_cnt == '0);
    assign acc_clear  = (state == st_read) && (chunk_cnt == '0);   // Before first chunk

endmodule

/* matmul_top.sv */
// ----------------------------------------------------------------------
// Matrix multiplier top level
// A and W RAMs, controller, systolic block, accumulator, C tile register
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module matmul_top
    import matmul_pkg::*;
(
    input  logic                  accumulator_done_top,
    input  logic                  rst_n,
    input  logic                  start,
    // Host write, A matrix
    input  logic                  in_ena,
    input  logic [word_w/8-1:0]   in_wea,
    input  logic [addr_w-1:0]     in_addr,
    input  logic [word_w-1:0]     in_data,
    // Host write, W matrix
    input  logic                  wt_ena,
    input  logic [word_w/8-1:0]   wt_wea,
    input  logic [addr_w-1:0]     wt_addr,
    input  logic [word_w-1:0]     wt_data,
    // Result tiles
    output logic [word_w-1:0]     c_tile,
    output logic                  tile_valid,
    output logic                  done
);

    logic                        in_rd_en;
    logic                        wt_rd_en;
    logic [addr_w-1:0]           in_rd_addr;
    logic [addr_w-1:0]           wt_rd_addr;
    logic [word_w-1:0]           a_block;     // RAM read data
    logic [word_w-1:0]           w_block;
    logic                        block_load;
    logic                        acc_clear;
    logic                        block_finish;
    logic [chunk_size*acc_w-1:0] block_out;
    logic                        tile_done;
    logic [word_w-1:0]           tile_sum;

    tile_ram #(.depth(in_depth)) in_ram_i (
        .accumulator_done_top (accumulator_done_top),
        .wr_en   (in_ena),
        .wr_be   (in_wea),
        .wr_addr (in_addr),
        .wr_data (in_data),
        .rd_en   (in_rd_en),
        .rd_addr (in_rd_addr),
        .rd_data (a_block)
    );

    tile_ram #(.depth(wt_depth)) wt_ram_i (
        .accumulator_done_top (accumulator_done_top),
        .wr_en   (wt_ena),
        .wr_be   (wt_wea),
        .wr_addr (wt_addr),
        .wr_data (wt_data),
        .rd_en   (wt_rd_en),
        .rd_addr (wt_rd_addr),
        .rd_data (w_block)
    );

    matmul_controller ctrl_i (
        .accumulator_done_top (accumulator_done_top),
        .rst_n      (rst_n),
        .start      (start),
        .tile_done  (tile_done),
        .in_rd_en   (in_rd_en),
        .wt_rd_en   (wt_rd_en),
        .in_rd_addr (in_rd_addr),
        .wt_rd_addr (wt_rd_addr),
        .block_load (block_load),
        .acc_clear  (acc_clear),
        .done       (done)
    );

    systolic_block sys_i (
        .accumulator_done_top (accumulator_done_top),
        .rst_n        (rst_n),
        .block_load   (block_load),
        .a_block      (a_block),
        .w_block      (w_block),
        .block_finish (block_finish),
        .block_out    (block_out)
    );

    block_accumulator acc_i (
        .accumulator_done_top (accumulator_done_top),
        .rst_n        (rst_n),
        .acc_clear    (acc_clear),
        .block_finish (block_finish),
        .block_out    (block_out),
        .tile_done    (tile_done),
        .tile_sum     (tile_sum)
    );

    // Output register, host must take each tile on tile_valid
    always_ff @(posedge accumulator_done_top) begin
        if (!rst_n) begin
            tile_valid <= 1'b0;
        end else begin
            tile_valid <= tile_done;
        end
    end

    always_ff @(posedge accumulator_done_top) begin
        if (tile_done) begin
            c_tile <= tile_sum;       // Held until next tile
        end
    end

endmodule

/* tb_clock_gen.sv */
// ----------------------------------------------------------------------
// Testbench clock, 8 ns period, and reset held low for 2 cycles
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen (
    output logic accumulator_done_top,
    output logic rst_n
);

    initial begin
        accumulator_done_top = 1'b0;
        forever #4 accumulator_done_top = ~accumulator_done_top;   // 125 MHz
    end

    // Low across two rising edges, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge accumulator_done_top);
        @(negedge accumulator_done_top);
        rst_n = 1'b1;
    end

endmodule

/* matmul_tb.sv */
// ----------------------------------------------------------------------
// Matrix multiplier testbench
// LFSR stimulus, A and W model, reference C tiles, tile checker
// and the six directed runs
// ----------------------------------------------------------------------

`timescale 1ns/1ps

module matmul_tb
    import matmul_pkg::*;
;

    // One tile is inner_chunks chunks plus the emit cycle
    localparam int run_limit = 4 * tile_count * (inner_chunks * (sys_latency + 2) + 1);

    logic                accumulator_done_top;
    logic                rst_n;
    logic                start;
    logic                in_ena;
    logic [word_w/8-1:0] in_wea;
    logic [addr_w-1:0]   in_addr;
    logic [word_w-1:0]   in_data;
    logic                wt_ena;
    logic [word_w/8-1:0] wt_wea;
    logic [addr_w-1:0]   wt_addr;
    logic [word_w-1:0]   wt_data;
    logic [word_w-1:0]   c_tile;
    logic                tile_valid;
    logic                done;

    logic [word_w-1:0] a_words  [in_depth];    // Model of the A RAM
    logic [word_w-1:0] w_words  [wt_depth];    // Model of the W RAM
    logic [word_w-1:0] got_tile [tile_count];  // Last tile seen at each index
    logic [31:0]       lfsr_state;
    int                tile_seen;              // tile_valid pulses so far
    int                failures;
    string             test_name;

    tb_clock_gen clock_gen_i (
        .accumulator_done_top (accumulator_done_top),
        .rst_n                (rst_n)
    );

    matmul_top matmul_top_i (
        .accumulator_done_top (accumulator_done_top),
        .rst_n      (rst_n),
        .start      (start),
        .in_ena     (in_ena),
        .in_wea     (in_wea),
        .in_addr    (in_addr),
        .in_data    (in_data),
        .wt_ena     (wt_ena),
        .wt_wea     (wt_wea),
        .wt_addr    (wt_addr),
        .wt_data    (wt_data),
        .c_tile     (c_tile),
        .tile_valid (tile_valid),
        .done       (done)
    );

    // Galois LFSR stepped once per bit with new bits entering at the bottom
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] bits;
        bits = '0;
        for (int n = 0; n < count; n++) begin
            bits = {bits[62:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;  // Taps 32 22 2 1
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return bits;
    endfunction

    function automatic logic [word_w-1:0] merge_bytes(input logic [word_w-1:0] old_word,
                                                      input logic [word_w-1:0] new_word,
                                                      input logic [word_w/8-1:0] mask);
        logic [word_w-1:0] merged;
        merged = old_word;
        for (int b = 0; b < word_w / 8; b++) begin
            if (mask[b]) begin
                merged[8*b +: 8] = new_word[8*b +: 8];   // Only enabled lanes change
            end
        end
        return merged;
    endfunction

    // A(row,k) and W(row,k) live in block k/2 + 2*(row/2) at bit 16*(2r+c)
    function automatic logic signed [data_w-1:0] a_elem(input int row, input int k);
        int addr;
        addr = k / block_size + inner_chunks * (row / block_size);
        return a_words[addr][data_w*(block_size*(row % block_size) + k % block_size) +: data_w];
    endfunction

    function automatic logic signed [data_w-1:0] w_elem(input int row, input int k);
        int addr;
        addr = k / block_size + inner_chunks * (row / block_size);
        return w_words[addr][data_w*(block_size*(row % block_size) + k % block_size) +: data_w];
    endfunction

    // C(row,col) is the low 16 bits of the sum over k of (A(row,k) * W(col,k)) >>> 8
    function automatic logic [data_w-1:0] ref_element(input int row, input int col);
        int sum;
        int prod;
        sum = 0;
        for (int k = 0; k < inner_dim; k++) begin
            prod = int'(a_elem(row, k)) * int'(w_elem(col, k));
            sum  = sum + (prod >>> frac_w);      // Scaled per product and wrapping at 32 bits
        end
        return sum[data_w-1:0];
    endfunction

    function automatic logic [word_w-1:0] expected_tile(input int t);
        logic [word_w-1:0] tile;
        int ti;
        int tj;
        ti = t / tile_cols;                      // Row-major order with the column fastest
        tj = t % tile_cols;
        for (int r = 0; r < block_size; r++) begin
            for (int c = 0; c < block_size; c++) begin
                tile[data_w*(block_size*r + c) +: data_w] =
                    ref_element(block_size*ti + r, block_size*tj + c);
            end
        end
        return tile;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected) begin
            failures++;
            $display("Fail %s: expected %h, actual %h", name, expected, actual);
            $display("Test FAILED");
            $fatal(1, "Mismatch in %s", name);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout in %s: %s", test_name, what);
        $display("Test FAILED");
        $fatal(1, "Simulation stopped on a timeout");
    endtask

    // One host write with the model following the byte mask
    task automatic host_write(input bit to_wt, input int addr,
                              input logic [word_w-1:0] data, input logic [word_w/8-1:0] mask);
        @(negedge accumulator_done_top);
        if (to_wt) begin
            wt_ena  = 1'b1;
            wt_wea  = mask;
            wt_addr = addr_w'(addr);
            wt_data = data;
            w_words[addr] = merge_bytes(w_words[addr], data, mask);
        end else begin
            in_ena  = 1'b1;
            in_wea  = mask;
            in_addr = addr_w'(addr);
            in_data = data;
            a_words[addr] = merge_bytes(a_words[addr], data, mask);
        end
        @(negedge accumulator_done_top);
        in_ena = 1'b0;
        wt_ena = 1'b0;
    endtask

    task automatic pulse_start();
        @(negedge accumulator_done_top);
        start = 1'b1;
        @(negedge accumulator_done_top);
        start = 1'b0;
    endtask

    // Done must come only after exactly one run of tiles
    task automatic wait_for_done(input int base);
        int cyc;
        cyc = 0;
        while (!done) begin
            if (cyc == run_limit) begin
                report_timeout("done did not rise within the run time limit");
            end
            @(negedge accumulator_done_top);
            cyc++;
        end
        check_value({test_name, " tiles before done"}, 64'(tile_count), 64'(tile_seen - base));
    endtask

    task automatic run_once();
        int base;
        base = tile_seen;
        pulse_start();
        wait_for_done(base);
    endtask

    // Compare each presented tile on the falling edge
    always @(negedge accumulator_done_top) begin
        int idx;
        if (rst_n && tile_valid) begin
            idx = tile_seen % tile_count;
            check_value({test_name, " done low during tiles"}, 64'(0), 64'(done));
            check_value({test_name, $sformatf(" tile %0d", idx)}, expected_tile(idx), c_tile);
            got_tile[idx] = c_tile;
            tile_seen++;
        end
    end

    initial begin
        int cyc;
        logic [word_w-1:0] word;
        start      = 1'b0;
        in_ena     = 1'b0;
        in_wea     = '0;
        in_addr    = '0;
        in_data    = '0;
        wt_ena     = 1'b0;
        wt_wea     = '0;
        wt_addr    = '0;
        wt_data    = '0;
        lfsr_state = 32'h18b3;
        tile_seen  = 0;
        failures   = 0;
        test_name  = "reset_state";
        for (int i = 0; i < in_depth; i++) a_words[i] = '0;
        for (int i = 0; i < wt_depth; i++) w_words[i] = '0;

        cyc = 0;
        while (rst_n !== 1'b1) begin
            if (cyc == 10) begin
                report_timeout("reset was never released");
            end
            @(negedge accumulator_done_top);
            cyc++;
        end

        // 1. Quiet outputs without a start
        repeat (20) begin
            @(negedge accumulator_done_top);
            check_value("reset_state tile_valid", 64'(0), 64'(tile_valid));
            check_value("reset_state done", 64'(0), 64'(done));
        end

        // 2. Full random A and W
        test_name = "random_multiply";
        for (int i = 0; i < in_depth; i++) host_write(1'b0, i, random_bits(64), 8'hff);
        for (int i = 0; i < wt_depth; i++) host_write(1'b1, i, random_bits(64), 8'hff);
        run_once();

        // 3. Partial byte masks on both RAMs
        test_name = "byte_enables";
        host_write(1'b0, 1, random_bits(64), 8'h0f);
        host_write(1'b0, 2, random_bits(64), 8'ha5);
        host_write(1'b1, 0, random_bits(64), 8'hf0);
        host_write(1'b1, 3, random_bits(64), 8'h3c);
        run_once();

        // 4. Negative A against 1.0 * identity
        test_name = "signed_fixed_point";
        for (int i = 0; i < in_depth; i++) begin
            for (int e = 0; e < chunk_size; e++) begin
                word[data_w*e +: data_w] = {1'b1, 15'(random_bits(15))};  // Sign bit set
            end
            host_write(1'b0, i, word, 8'hff);
        end
        for (int i = 0; i < wt_depth; i++) begin
            for (int r = 0; r < block_size; r++) begin
                for (int c = 0; c < block_size; c++) begin
                    // Diagonal when row 2j+r meets column 2k+c
                    word[data_w*(block_size*r + c) +: data_w] =
                        ((block_size*(i / inner_chunks) + r) == (block_size*(i % inner_chunks) + c))
                        ? 16'h0100 : 16'h0000;
                end
            end
            host_write(1'b1, i, word, 8'hff);
        end
        run_once();
        for (int t = 0; t < tile_count; t++) begin
            check_value($sformatf("signed_fixed_point A block %0d", t),
                        a_words[t % tile_cols + inner_chunks * (t / tile_cols)], got_tile[t]);
        end

        // 5. Second start inside the run is dropped
        test_name = "start_while_busy";
        cyc = tile_seen;
        pulse_start();
        repeat (20) @(negedge accumulator_done_top);   // Into the second tile
        pulse_start();
        wait_for_done(cyc);

        // 6. Start from st_done with the same data
        test_name = "restart_after_done";
        cyc = tile_seen;
        pulse_start();
        check_value("restart_after_done done dropped", 64'(0), 64'(done));
        wait_for_done(cyc);

        if (failures == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* filelist.f */
matmul_pkg.sv
tile_ram.sv
mac_pe.sv
systolic_block.sv
block_accumulator.sv
matmul_controller.sv
matmul_top.sv
tb_clock_gen.sv
matmul_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the matmul testbench with Verilator and run it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing -Wno-fatal -f filelist.f \
    --top-module matmul_tb --Mdir obj_dir -o matmul_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/matmul_sim 2>&1)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "Test OK"; then
    exit 0
fi
echo "Pass line not found in the simulation output"
exit 1
